/* sim.f */
src/webp_quant_pkg.sv
src/dc_err_pkg.sv
src/quantize_single.sv
src/dc_error_diffuser.sv
src/dc_err_line.sv
src/chroma_dc_correct.sv
dv/tb_chroma_dc_correct.sv

/* Makefile */
.PHONY: all run clean

all: obj_dir/Vtb_chroma_dc_correct

obj_dir/Vtb_chroma_dc_correct: sim.f $(shell cat sim.f)
	verilator --binary --timing -j 0 -f sim.f --top-module tb_chroma_dc_correct

run: obj_dir/Vtb_chroma_dc_correct
	@out="$$(./obj_dir/Vtb_chroma_dc_correct)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir

/* dv/tb_chroma_dc_correct.sv */
`timescale 1ns/1ps

module tb_chroma_dc_correct;

    localparam int MB_COLS = 8;
    localparam int MB_ROWS = 4;
    localparam int FRAMES  = 3;
    localparam int TIMEOUT = 50;
    localparam int XW      = $clog2(MB_COLS);

    logic                          clk;
    logic                          rst_n;
    logic                          start;
    logic [XW-1:0]                 x;
    logic [9:0]                    y;
    dc_err_pkg::dc_block_t         dc_in;
    webp_quant_pkg::quant_matrix_t qm;
    dc_err_pkg::dc_block_t         dc_out;
    logic                          done;

    logic [31:0]                   lcg_state;
    dc_err_pkg::nbr_err_t          top_mem [MB_COLS];
    dc_err_pkg::nbr_err_t          left_reg;
    int                            mismatches;
    int                            timeouts;
    int                            protocol_errs;

    chroma_dc_correct #(.MB_COLS(MB_COLS)) chroma_dc_correct_inst (
        .clk(clk), .rst_n(rst_n), .start(start), .x(x), .y(y),
        .dc_in(dc_in), .qm(qm), .dc_out(dc_out), .done(done)
    );

    always #5 clk = ~clk;

    //--------------------------------------------------
    // Stimulus
    //--------------------------------------------------

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic pick_matrix();
        logic [31:0] r;
        r = next_rand();
        qm.q       = 16'(8 + int'(r[31:16]) % 120);
        qm.iq      = 16'((1 << webp_quant_pkg::QFIX) / int'(qm.q));
        r = next_rand();
        qm.bias    = {15'd0, r[31:15]};
        // Largest magnitude that still rounds to zero
        qm.zthresh = ((32'd1 << webp_quant_pkg::QFIX) - 32'd1 - qm.bias) / 32'(qm.iq);
    endtask

    function automatic webp_quant_pkg::coeff_t rand_coeff();
        logic [31:0] r;
        int          zt;
        int          v;
        r  = next_rand();
        zt = int'(qm.zthresh);
        if (r[31:24] < 8'd51) begin
            v = int'(r[23:8]) % (2 * zt + 1) - zt;
        end else begin
            v = int'(r[23:8]) % 1201 - 600;
        end
        return webp_quant_pkg::coeff_t'(v);
    endfunction

    //--------------------------------------------------
    // Reference model
    //--------------------------------------------------

    function automatic webp_quant_pkg::coeff_t diffused(
        input webp_quant_pkg::coeff_t c,
        input webp_quant_pkg::qerr_t  t,
        input webp_quant_pkg::qerr_t  l
    );
        int sum;
        sum = dc_err_pkg::W_TOP * int'(t) + dc_err_pkg::W_LEFT * int'(l);
        return webp_quant_pkg::coeff_t'((sum >>> dc_err_pkg::W_SHIFT) + int'(c));
    endfunction

    task automatic quant_model(
        input  webp_quant_pkg::coeff_t        c,
        input  webp_quant_pkg::quant_matrix_t m,
        output webp_quant_pkg::coeff_t        lv,
        output webp_quant_pkg::qerr_t         e
    );
        longint mag;
        longint qv;
        longint rem;
        mag = (c < 0) ? -longint'(c) : longint'(c);
        qv  = 0;
        if (mag > longint'(m.zthresh)) begin
            qv = (mag * longint'(m.iq) + longint'(m.bias)) >>> webp_quant_pkg::QFIX;
            qv = qv * longint'(m.q);
        end
        rem = mag - qv;
        if (c < 0) begin
            qv  = -qv;
            rem = -rem;
        end
        lv = webp_quant_pkg::coeff_t'(qv);
        e  = webp_quant_pkg::qerr_t'(rem >>> webp_quant_pkg::DSCALE);
    endtask

    // Blocks 0..3 of one channel in raster order
    task automatic model_channel(
        input  webp_quant_pkg::coeff_t [3:0] c,
        input  webp_quant_pkg::qerr_t        t0,
        input  webp_quant_pkg::qerr_t        t1,
        input  webp_quant_pkg::qerr_t        l0,
        input  webp_quant_pkg::qerr_t        l1,
        output webp_quant_pkg::coeff_t [3:0] lv,
        output webp_quant_pkg::qerr_t  [3:0] e
    );
        quant_model(diffused(c[0], t0, l0), qm, lv[0], e[0]);
        quant_model(diffused(c[1], t1, e[0]), qm, lv[1], e[1]);
        quant_model(diffused(c[2], e[0], l1), qm, lv[2], e[2]);
        quant_model(diffused(c[3], e[1], e[2]), qm, lv[3], e[3]);
    endtask

    function automatic webp_quant_pkg::qerr_t three_quarters(input webp_quant_pkg::qerr_t e);
        return webp_quant_pkg::qerr_t'((int'(e) * 3) >>> 2);
    endfunction

    task automatic model_mb(
        input  int                    col,
        input  int                    row,
        input  dc_err_pkg::dc_block_t din,
        output dc_err_pkg::dc_block_t want
    );
        dc_err_pkg::nbr_err_t        t;
        dc_err_pkg::nbr_err_t        l;
        webp_quant_pkg::qerr_t [3:0] eu;
        webp_quant_pkg::qerr_t [3:0] ev;
        t = (row != 0) ? top_mem[col] : '0;
        l = (col != 0) ? left_reg : '0;
        model_channel(din.u, t.u0, t.u1, l.u0, l.u1, want.u, eu);
        model_channel(din.v, t.v0, t.v1, l.v0, l.v1, want.v, ev);
        left_reg.u0     = eu[1];
        left_reg.u1     = three_quarters(eu[3]);
        left_reg.v0     = ev[1];
        left_reg.v1     = three_quarters(ev[3]);
        top_mem[col].u0 = eu[2];
        top_mem[col].u1 = webp_quant_pkg::qerr_t'(eu[3] - left_reg.u1);
        top_mem[col].v0 = ev[2];
        top_mem[col].v1 = webp_quant_pkg::qerr_t'(ev[3] - left_reg.v1);
    endtask

    //--------------------------------------------------
    // Checks
    //--------------------------------------------------

    task automatic check_block(
        input string                 name,
        input dc_err_pkg::dc_block_t want,
        input dc_err_pkg::dc_block_t got
    );
        if (got !== want) begin
            mismatches++;
            $display("Mismatch %s dc_out: expected %h, actual %h", name, want, got);
        end
    endtask

    task automatic check_latency(input string name, input int want, input int got);
        if (got != want) begin
            mismatches++;
            $display("Mismatch %s latency: expected %0d, actual %0d", name, want, got);
        end
    endtask

    task automatic run_mb(input int frame, input int col, input int row, input bit busy_start);
        dc_err_pkg::dc_block_t blk;
        dc_err_pkg::dc_block_t want;
        string                 name;
        int                    i;
        int                    cycles;
        logic                  seen;
        name = $sformatf("frame%0d_x%0d_y%0d", frame, col, row);
        for (i = 0; i < 4; i++) begin
            blk.u[i] = rand_coeff();
            blk.v[i] = rand_coeff();
        end
        model_mb(col, row, blk, want);
        @(posedge clk);
        x     <= XW'(col);
        y     <= 10'(row);
        dc_in <= blk;
        start <= 1'b1;
        @(posedge clk);
        start  <= 1'b0;
        cycles = 0;
        seen   = 1'b0;
        // Latency counted from the edge that samples start
        while (!seen && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            start <= busy_start && (cycles == 3);
            @(negedge clk);
            seen = done;
        end
        if (!seen) begin
            timeouts++;
            $display("Timeout: done never rose within %0d cycles in %s", TIMEOUT, name);
        end else begin
            check_latency(name, (row != 0) ? 10 : 8, cycles);
            check_block(name, want, dc_out);
            @(negedge clk);
            if (done !== 1'b0) begin
                protocol_errs++;
                $display("Done stayed high longer than one cycle in %s", name);
            end
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         <= 1'b0;
        start         <= 1'b0;
        x             <= '0;
        y             <= '0;
        dc_in         <= '0;
        qm            = '0;
        left_reg      = '0;
        mismatches    = 0;
        timeouts      = 0;
        protocol_errs = 0;
        lcg_state     = 32'h690ce69e;
        pick_matrix();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (done !== 1'b0) begin
                protocol_errs++;
                $display("Done went high after reset with no start");
            end
        end
        for (int f = 0; f < FRAMES; f++) begin
            for (int r = 0; r < MB_ROWS; r++) begin
                for (int c = 0; c < MB_COLS; c++) begin
                    if (timeouts == 0) begin
                        run_mb(f, c, r, (((f * MB_ROWS + r) * MB_COLS + c) % 3) == 1);
                    end
                end
            end
        end
        $display("Errors: %0d mismatches, %0d timeouts, %0d protocol",
                 mismatches, timeouts, protocol_errs);
        if (mismatches + timeouts + protocol_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* src/chroma_dc_correct.sv */
`timescale 1ns/1ps

module chroma_dc_correct #(
    parameter int MB_COLS = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [$clog2(MB_COLS)-1:0]    x,
    input  logic [9:0]                    y,
    input  dc_err_pkg::dc_block_t         dc_in,
    input  webp_quant_pkg::quant_matrix_t qm,
    output dc_err_pkg::dc_block_t         dc_out,
    output logic                          done
);

    logic                        top_rd_en;
    logic [$clog2(MB_COLS)-1:0]  top_rd_addr;
    dc_err_pkg::nbr_err_t        top_err;
    dc_err_pkg::nbr_err_t        left_err;
    webp_quant_pkg::coeff_t      u_in;
    webp_quant_pkg::coeff_t      v_in;
    webp_quant_pkg::coeff_t      u_level;
    webp_quant_pkg::coeff_t      v_level;
    webp_quant_pkg::qerr_t       u_err;
    webp_quant_pkg::qerr_t       v_err;
    dc_err_pkg::chroma_err_t     blk_err;

    dc_error_diffuser #(.MB_COLS(MB_COLS)) diffuser_inst (
        .clk(clk), .rst_n(rst_n), .start(start), .x(x), .y(y), .dc_in(dc_in),
        .top_err(top_err), .left_err(left_err),
        .top_rd_en(top_rd_en), .top_rd_addr(top_rd_addr),
        .u_in(u_in), .v_in(v_in), .u_level(u_level), .v_level(v_level),
        .u_err(u_err), .v_err(v_err),
        .dc_out(dc_out), .blk_err(blk_err), .done(done)
    );

    // One quantizer per chroma channel
    quantize_single u_quant_inst (
        .clk(clk), .rst_n(rst_n), .coeff(u_in), .qm(qm), .level(u_level), .err(u_err)
    );

    quantize_single v_quant_inst (
        .clk(clk), .rst_n(rst_n), .coeff(v_in), .qm(qm), .level(v_level), .err(v_err)
    );

    dc_err_line #(.MB_COLS(MB_COLS)) err_line_inst (
        .clk(clk), .rst_n(rst_n), .top_rd_en(top_rd_en), .top_rd_addr(top_rd_addr),
        .top_err(top_err), .left_err(left_err), .done(done), .x(x), .blk_err(blk_err)
    );

endmodule

/* src/dc_err_line.sv */
`timescale 1ns/1ps

module dc_err_line #(
    parameter int MB_COLS = 64
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        top_rd_en,
    input  logic [$clog2(MB_COLS)-1:0]  top_rd_addr,
    output dc_err_pkg::nbr_err_t        top_err,
    output dc_err_pkg::nbr_err_t        left_err,
    input  logic                        done,
    input  logic [$clog2(MB_COLS)-1:0]  x,
    input  dc_err_pkg::chroma_err_t     blk_err
);

    dc_err_pkg::nbr_err_t mem [MB_COLS];
    dc_err_pkg::nbr_err_t new_top;
    dc_err_pkg::nbr_err_t new_left;

    // Three quarters of the block 3 error
    function automatic webp_quant_pkg::qerr_t three_quarter(input webp_quant_pkg::qerr_t e);
        return webp_quant_pkg::qerr_t'((3 * int'(e)) >>> 2);
    endfunction

    always_comb begin
        new_left.u0 = blk_err.u_err[0];
        new_left.u1 = three_quarter(blk_err.u_err[2]);
        new_left.v0 = blk_err.v_err[0];
        new_left.v1 = three_quarter(blk_err.v_err[2]);
        new_top.u0  = blk_err.u_err[1];
        new_top.u1  = webp_quant_pkg::qerr_t'(blk_err.u_err[2] - new_left.u1);
        new_top.v0  = blk_err.v_err[1];
        new_top.v1  = webp_quant_pkg::qerr_t'(blk_err.v_err[2] - new_left.v1);
    end

    //--------------------------------------------------
    // Column memory, registered read
    //--------------------------------------------------

    always_ff @(posedge clk) begin
        if (done) begin
            mem[x] <= new_top;
        end
        if (top_rd_en) begin
            top_err <= mem[top_rd_addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_err <= '0;
        end else if (done) begin
            left_err <= new_left;
        end
    end

endmodule

/* src/dc_error_diffuser.sv */
`timescale 1ns/1ps

module dc_error_diffuser #(
    parameter int MB_COLS = 64
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [$clog2(MB_COLS)-1:0]  x,
    input  logic [9:0]                  y,
    input  dc_err_pkg::dc_block_t       dc_in,
    input  dc_err_pkg::nbr_err_t        top_err,
    input  dc_err_pkg::nbr_err_t        left_err,
    output logic                        top_rd_en,
    output logic [$clog2(MB_COLS)-1:0]  top_rd_addr,
    output webp_quant_pkg::coeff_t      u_in,
    output webp_quant_pkg::coeff_t      v_in,
    input  webp_quant_pkg::coeff_t      u_level,
    input  webp_quant_pkg::coeff_t      v_level,
    input  webp_quant_pkg::qerr_t       u_err,
    input  webp_quant_pkg::qerr_t       v_err,
    output dc_err_pkg::dc_block_t       dc_out,
    output dc_err_pkg::chroma_err_t     blk_err,
    output logic                        done
);

    dc_err_pkg::diff_state_e state;
    dc_err_pkg::diff_state_e state_nxt;
    logic                    fin;
    logic                    has_top;
    logic                    has_left;
    dc_err_pkg::nbr_err_t    top_sel;
    dc_err_pkg::nbr_err_t    left_sel;
    dc_err_pkg::nbr_err_t    top_q;
    dc_err_pkg::nbr_err_t    left_q;
    webp_quant_pkg::qerr_t   u_e0;
    webp_quant_pkg::qerr_t   v_e0;
    dc_err_pkg::dc_block_t   res;
    dc_err_pkg::chroma_err_t err_q;

    // Coefficient plus weighted top and left error
    function automatic webp_quant_pkg::coeff_t diffuse(
        input webp_quant_pkg::coeff_t c,
        input webp_quant_pkg::qerr_t  t,
        input webp_quant_pkg::qerr_t  l
    );
        int acc;
        acc = int'(t) * dc_err_pkg::W_TOP + int'(l) * dc_err_pkg::W_LEFT;
        return webp_quant_pkg::coeff_t'(int'(c) + (acc >>> dc_err_pkg::W_SHIFT));
    endfunction

    //--------------------------------------------------
    // Sequencing
    //--------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            dc_err_pkg::IDLE: begin
                if (start) begin
                    if (y != '0) begin
                        state_nxt = dc_err_pkg::EN;
                    end else if (x != '0) begin
                        state_nxt = dc_err_pkg::LEFT;
                    end else begin
                        state_nxt = dc_err_pkg::NONE;
                    end
                end
            end
            dc_err_pkg::EN:    state_nxt = dc_err_pkg::WAIT;
            dc_err_pkg::WAIT:  state_nxt = (x != '0) ? dc_err_pkg::BOTH : dc_err_pkg::TOP;
            dc_err_pkg::BOTH,
            dc_err_pkg::TOP,
            dc_err_pkg::LEFT,
            dc_err_pkg::NONE:  state_nxt = dc_err_pkg::STEP1;
            dc_err_pkg::STEP1: state_nxt = dc_err_pkg::STEP2;
            dc_err_pkg::STEP2: state_nxt = dc_err_pkg::STEP3;
            dc_err_pkg::STEP3: state_nxt = dc_err_pkg::STEP4;
            dc_err_pkg::STEP4: state_nxt = dc_err_pkg::STEP5;
            dc_err_pkg::STEP5: state_nxt = dc_err_pkg::STEP6;
            // Held a second cycle until block 3 leaves the quantizer
            dc_err_pkg::STEP6: state_nxt = fin ? dc_err_pkg::IDLE : dc_err_pkg::STEP6;
            default:           state_nxt = dc_err_pkg::IDLE;
        endcase
    end

    // Absent neighbors contribute zero
    assign has_top  = (state == dc_err_pkg::BOTH) || (state == dc_err_pkg::TOP);
    assign has_left = (state == dc_err_pkg::BOTH) || (state == dc_err_pkg::LEFT);
    assign top_sel  = has_top ? top_err : '0;
    assign left_sel = has_left ? left_err : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= dc_err_pkg::IDLE;
            fin         <= 1'b0;
            done        <= 1'b0;
            top_rd_en   <= 1'b0;
            top_rd_addr <= '0;
            u_in        <= '0;
            v_in        <= '0;
        end else begin
            state     <= state_nxt;
            fin       <= (state == dc_err_pkg::STEP6) && !fin;
            done      <= (state == dc_err_pkg::STEP6) && fin;
            top_rd_en <= (state == dc_err_pkg::EN);
            if (state == dc_err_pkg::EN) begin
                top_rd_addr <= x;
            end
            case (state)
                dc_err_pkg::BOTH,
                dc_err_pkg::TOP,
                dc_err_pkg::LEFT,
                dc_err_pkg::NONE: begin
                    u_in <= diffuse(dc_in.u[0], top_sel.u0, left_sel.u0);
                    v_in <= diffuse(dc_in.v[0], top_sel.v0, left_sel.v0);
                end
                // Block 0 error comes straight from the quantizer
                dc_err_pkg::STEP2: begin
                    u_in <= diffuse(dc_in.u[1], top_q.u1, u_err);
                    v_in <= diffuse(dc_in.v[1], top_q.v1, v_err);
                end
                dc_err_pkg::STEP3: begin
                    u_in <= diffuse(dc_in.u[2], u_e0, left_q.u1);
                    v_in <= diffuse(dc_in.v[2], v_e0, left_q.v1);
                end
                dc_err_pkg::STEP5: begin
                    u_in <= diffuse(dc_in.u[3], err_q.u_err[0], u_err);
                    v_in <= diffuse(dc_in.v[3], err_q.v_err[0], v_err);
                end
                default: ;
            endcase
        end
    end

    //--------------------------------------------------
    // Result collection
    //--------------------------------------------------

    always_ff @(posedge clk) begin
        case (state)
            dc_err_pkg::BOTH,
            dc_err_pkg::TOP,
            dc_err_pkg::LEFT,
            dc_err_pkg::NONE: begin
                top_q  <= top_sel;
                left_q <= left_sel;
            end
            dc_err_pkg::STEP2: begin
                res.u[0] <= u_level;
                res.v[0] <= v_level;
                u_e0     <= u_err;
                v_e0     <= v_err;
            end
            dc_err_pkg::STEP4: begin
                res.u[1]       <= u_level;
                res.v[1]       <= v_level;
                err_q.u_err[0] <= u_err;
                err_q.v_err[0] <= v_err;
            end
            dc_err_pkg::STEP5: begin
                res.u[2]       <= u_level;
                res.v[2]       <= v_level;
                err_q.u_err[1] <= u_err;
                err_q.v_err[1] <= v_err;
            end
            dc_err_pkg::STEP6: begin
                if (fin) begin
                    res.u[3]       <= u_level;
                    res.v[3]       <= v_level;
                    err_q.u_err[2] <= u_err;
                    err_q.v_err[2] <= v_err;
                end
            end
            default: ;
        endcase
    end

    assign dc_out  = res;
    assign blk_err = err_q;

endmodule

/* src/quantize_single.sv */
`timescale 1ns/1ps

module quantize_single (
    input  logic                          clk,
    input  logic                          rst_n,
    input  webp_quant_pkg::coeff_t        coeff,
    input  webp_quant_pkg::quant_matrix_t qm,
    output webp_quant_pkg::coeff_t        level,
    output webp_quant_pkg::qerr_t         err
);

    logic               sign;
    logic [31:0]        mag;
    logic [63:0]        scaled;
    logic [31:0]        qv;
    logic signed [31:0] qv_s;
    logic signed [31:0] rem;

    assign sign = coeff[15];
    assign mag  = 32'(sign ? -int'(coeff) : int'(coeff));

    // Reciprocal multiply with rounding bias
    assign scaled = 64'(mag) * 64'(qm.iq) + 64'(qm.bias);

    // Dead zone at or below zthresh
    assign qv = (mag > qm.zthresh) ? 32'(scaled >> webp_quant_pkg::QFIX) * 32'(qm.q) : '0;

    // Sign of the coefficient goes back onto value and remainder
    assign qv_s = sign ? -signed'(qv) : signed'(qv);
    assign rem  = sign ? -signed'(mag - qv) : signed'(mag - qv);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level <= '0;
            err   <= '0;
        end else begin
            level <= webp_quant_pkg::coeff_t'(qv_s);
            err   <= webp_quant_pkg::qerr_t'(rem >>> webp_quant_pkg::DSCALE);
        end
    end

endmodule

/* src/dc_err_pkg.sv */
package dc_err_pkg;

    typedef enum logic [3:0] {
        IDLE, EN, WAIT,
        BOTH, TOP, LEFT, NONE,
        STEP1, STEP2, STEP3, STEP4, STEP5, STEP6
    } diff_state_e;

    // Index 0 is the top-left block, raster order within the macroblock
    typedef struct packed {
        webp_quant_pkg::coeff_t [3:0] u;
        webp_quant_pkg::coeff_t [3:0] v;
    } dc_block_t;

    // Top or left neighbor errors of one macroblock
    typedef struct packed {
        webp_quant_pkg::qerr_t u0;
        webp_quant_pkg::qerr_t u1;
        webp_quant_pkg::qerr_t v0;
        webp_quant_pkg::qerr_t v1;
    } nbr_err_t;

    // Index 0 holds block 1, index 2 holds block 3
    typedef struct packed {
        webp_quant_pkg::qerr_t [2:0] u_err;
        webp_quant_pkg::qerr_t [2:0] v_err;
    } chroma_err_t;

    localparam int W_TOP   = 7;
    localparam int W_LEFT  = 8;
    localparam int W_SHIFT = 3;

endpackage

/* src/webp_quant_pkg.sv */
package webp_quant_pkg;

    // DC coefficient, before or after quantization
    typedef logic signed [15:0] coeff_t;

    // Diffusion error carried between blocks
    typedef logic signed [7:0] qerr_t;

    // Quantizer values for one coefficient position
    typedef struct packed {
        logic [15:0] q;
        logic [15:0] iq;
        logic [31:0] bias;
        logic [31:0] zthresh;
    } quant_matrix_t;

    //--------------------------------------------------
    // Fixed-point constants
    //--------------------------------------------------

    // iq is 2^QFIX / q
    localparam int QFIX = 17;

    // Down-shift applied to the remainder
    localparam int DSCALE = 1;

endpackage
